/* design/usb_link_params.svh */
// Link-wide constants for the SPI host link and ULPI register sequencer; include where needed
`ifndef USB_LINK_PARAMS_SVH
`define USB_LINK_PARAMS_SVH

// Frames the decoder can hold at once, one credit per frame
`define LINK_CREDITS 2

// Flops in each SPI input synchronizer chain
`define SYNC_STAGES 2

// ULPI TXCMD prefixes, top two bits of the command byte
`define ULPI_CMD_REG_WRITE 2'b10 // Register write
`define ULPI_CMD_REG_READ  2'b11 // Register read

// Short-format code that forwards the second byte to the controller
`define SHORT_CODE_DATA 7'd1

`endif

/* design/usb_link_pkg.sv */
// Types shared by the host link blocks; reference them as usb_link_pkg::name
package usb_link_pkg;

    // First MOSI byte of a frame, decoded in one of two formats
    // Bit 7 is the long flag in both views, so it picks the view to trust
    typedef union packed {
        struct packed {
            logic       long_fmt; // Set for register commands
            logic       write;    // 1 write, 0 read
            logic [5:0] addr;     // ULPI immediate register address
        } reg_cmd;
        struct packed {
            logic       long_fmt; // Clear for short commands
            logic [6:0] code;     // Short command code
        } short_cmd;
    } spi_cmd_u;

    // Register operation requested from the ULPI sequencer
    typedef enum logic {
        ULPI_OP_READ  = 1'b0,
        ULPI_OP_WRITE = 1'b1
    } ulpi_op_e;

endpackage

/* design/cmd_stream_if.sv */
// Frame channel from the SPI port to the decoder and register channel to the ULPI sequencer
`timescale 1ns/1ps

interface cmd_stream_if;

    // Frame channel, credit based, no back-pressure wire
    logic       frame_valid;   // One-cycle pulse per accepted frame
    logic [7:0] cmd_byte;      // First MOSI byte
    logic [7:0] data_byte;     // Second MOSI byte
    logic       credit_return; // One pulse per retired frame

    // Register channel, request held until done
    logic                   reg_req;
    usb_link_pkg::ulpi_op_e reg_op;
    logic [5:0]             reg_addr;
    logic [7:0]             reg_wdata;
    logic [7:0]             reg_rdata; // Valid with reg_done on reads
    logic                   reg_done;  // One-cycle pulse

    modport spi_side (
        output frame_valid, cmd_byte, data_byte,
        input  credit_return
    );

    modport dec_side (
        input  frame_valid, cmd_byte, data_byte,
        output credit_return
    );

    modport req_side (
        output reg_req, reg_op, reg_addr, reg_wdata,
        input  reg_rdata, reg_done
    );

    modport ulpi_side (
        input  reg_req, reg_op, reg_addr, reg_wdata,
        output reg_rdata, reg_done
    );

endinterface

/* design/spi_slave_port.sv */
// SPI mode 0 slave front end; builds two-byte frames, spends credits and returns status/reply
`timescale 1ns/1ps
`include "usb_link_params.svh"

module spi_slave_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               sclk,
    input  logic               ss,
    input  logic               mosi,
    input  logic               sta,        // Analyzer status, reported in status bit 7
    input  logic               busy,       // Decoder holds unfinished frames
    input  logic [7:0]         reply_byte, // Result of the last register read
    output logic               miso,
    output logic               err,
    cmd_stream_if.spi_side     frames
);

    localparam int CW = $clog2(`LINK_CREDITS + 1);

    // Synchronizer chains, one column per pin {sclk, ss, mosi}
    logic [`SYNC_STAGES-1:0][2:0] pin_sync;
    logic                         sclk_s, ss_s, mosi_s;
    logic                         sclk_d, ss_d;     // Previous synced levels for edge detect
    logic                         sclk_rise, sclk_fall, ss_fall, ss_rise;
    logic                         active;           // Slave selected

    logic [4:0]    bit_cnt;  // Bits received this frame, saturates at 16
    logic [7:0]    rx_shift;
    logic [7:0]    rx_next;  // Shift register with the current MOSI bit folded in
    logic [7:0]    cmd_q;    // First byte, held while the second arrives
    logic [7:0]    tx_shift; // MSB drives MISO
    logic [CW-1:0] credits;
    logic          frame_done, spend, drop, cut;

    always_ff @(posedge clk) begin
        if (rst) begin
            pin_sync <= {`SYNC_STAGES{3'b010}}; // Idle bus: SCLK low, SS high
        end else begin
            pin_sync <= {pin_sync[`SYNC_STAGES-2:0], {sclk, ss, mosi}};
        end
    end

    assign {sclk_s, ss_s, mosi_s} = pin_sync[`SYNC_STAGES-1];

    assign active    = ~ss_s;
    assign sclk_rise = active & sclk_s & ~sclk_d;
    assign sclk_fall = active & ~sclk_s & sclk_d;
    assign ss_fall   = ~ss_s & ss_d;
    assign ss_rise   = ss_s & ~ss_d;
    assign rx_next   = {rx_shift[6:0], mosi_s};

    assign frame_done = sclk_rise && (bit_cnt == 5'd15);         // 16th bit sampled
    assign spend      = frame_done && (credits != '0);
    assign drop       = frame_done && (credits == '0);           // Decoder full, frame lost
    assign cut        = ss_rise && (bit_cnt != 5'd0) && (bit_cnt != 5'd16);

    // Edge history, bit counting and MISO shifting
    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_d   <= 1'b0;
            ss_d     <= 1'b1;
            bit_cnt  <= '0;
            tx_shift <= '0;
        end else begin
            sclk_d <= sclk_s;
            ss_d   <= ss_s;
            if (ss_fall) begin
                bit_cnt  <= '0;
                tx_shift <= {sta, err, busy, 5'b0}; // Status bit 7 ready before the first edge
            end else begin
                if (sclk_rise && bit_cnt != 5'd16) begin
                    bit_cnt <= bit_cnt + 5'd1;
                end
                if (sclk_fall) begin
                    // Second byte starts after the 8th bit
                    tx_shift <= (bit_cnt == 5'd8) ? reply_byte : {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    // Receive shifting and frame payload, no reset needed
    always_ff @(posedge clk) begin
        if (sclk_rise && bit_cnt != 5'd16) begin
            rx_shift <= rx_next;
            if (bit_cnt == 5'd7) cmd_q <= rx_next; // Command byte complete
        end
        if (spend) begin
            frames.cmd_byte  <= cmd_q;
            frames.data_byte <= rx_next;
        end
    end

    // Credits, frame strobe and error flag
    always_ff @(posedge clk) begin
        if (rst) begin
            credits            <= CW'(`LINK_CREDITS);
            frames.frame_valid <= 1'b0;
            err                <= 1'b0;
        end else begin
            credits            <= credits - CW'(spend) + CW'(frames.credit_return);
            frames.frame_valid <= spend;
            if (cut || drop) begin
                err <= 1'b1;
            end else if (spend) begin
                err <= 1'b0; // Clean frame clears a past error
            end
        end
    end

    assign miso = active & tx_shift[7]; // Low while deselected

    // Decoder never returns more credits than were spent
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CW'(`LINK_CREDITS));

endmodule

/* design/cmd_decoder.sv */
// Command decoder; queues frames, turns long commands into ULPI requests, forwards data bytes
`timescale 1ns/1ps
`include "usb_link_params.svh"

module cmd_decoder (
    input  logic           clk,
    input  logic           rst,
    cmd_stream_if.dec_side frames,
    cmd_stream_if.req_side regs,
    output logic [7:0]     data_out,
    output logic           data_out_valid,
    output logic           busy,
    output logic [7:0]     reply_byte
);

    localparam int PW = $clog2(`LINK_CREDITS);
    localparam int CW = $clog2(`LINK_CREDITS + 1);

    localparam logic [1:0] S_IDLE = 2'd0; // Decode head frame
    localparam logic [1:0] S_REG  = 2'd1; // Register request outstanding
    localparam logic [1:0] S_DONE = 2'd2; // Retire register frame

    logic [15:0]            fifo_mem [`LINK_CREDITS]; // {cmd, data}
    logic [PW-1:0]          wr_ptr, rd_ptr;
    logic [CW-1:0]          count;
    logic [1:0]             state;
    usb_link_pkg::spi_cmd_u head_cmd;
    logic [7:0]             head_data;
    logic                   empty, push, pop, decode;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(`LINK_CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty     = (count == '0);
    assign push      = frames.frame_valid;
    assign head_cmd  = fifo_mem[rd_ptr][15:8];
    assign head_data = fifo_mem[rd_ptr][7:0];
    assign decode    = (state == S_IDLE) && !empty;

    // Short frames retire in the decode cycle, register frames after done
    assign pop = (decode && !head_cmd.short_cmd.long_fmt) || (state == S_DONE);
    assign frames.credit_return = pop;

    assign data_out       = head_data;
    assign data_out_valid = decode && !head_cmd.short_cmd.long_fmt
                            && (head_cmd.short_cmd.code == `SHORT_CODE_DATA);
    assign busy           = !empty;

    // Request fields stay stable, the head is not popped until S_DONE
    assign regs.reg_req   = (state == S_REG);
    assign regs.reg_op    = head_cmd.reg_cmd.write ? usb_link_pkg::ULPI_OP_WRITE
                                                   : usb_link_pkg::ULPI_OP_READ;
    assign regs.reg_addr  = head_cmd.reg_cmd.addr;
    assign regs.reg_wdata = head_data;

    always_ff @(posedge clk) begin
        if (push) fifo_mem[wr_ptr] <= {frames.cmd_byte, frames.data_byte};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            state      <= S_IDLE;
            reply_byte <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            count <= count + CW'(push) - CW'(pop);
            case (state)
                S_IDLE: if (decode && head_cmd.reg_cmd.long_fmt) state <= S_REG;
                S_REG: begin
                    if (regs.reg_done) begin
                        state <= S_DONE; // Drops reg_req next cycle
                        if (regs.reg_op == usb_link_pkg::ULPI_OP_READ) begin
                            reply_byte <= regs.reg_rdata; // Sent in the next frame
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Port only sends a frame when it holds a credit, so the queue never overflows
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count != CW'(`LINK_CREDITS)) || pop);

endmodule

/* design/ulpi_reg_access.sv */
// ULPI register sequencer; runs immediate register reads and writes for the decoder
`timescale 1ns/1ps
`include "usb_link_params.svh"

module ulpi_reg_access (
    input  logic            clk,
    input  logic            rst,
    input  logic [7:0]      ulpi_data_in,
    input  logic            ulpi_dir,
    input  logic            ulpi_nxt,
    output logic [7:0]      ulpi_data_out,
    output logic            ulpi_stp,
    cmd_stream_if.ulpi_side regs
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_TXCMD = 3'd1; // TXCMD on the bus, wait for NXT
    localparam logic [2:0] S_WDATA = 3'd2; // Write data, wait for NXT
    localparam logic [2:0] S_STOP  = 3'd3; // STP pulse ends the write
    localparam logic [2:0] S_TURN  = 3'd4; // Bus turnaround to the PHY
    localparam logic [2:0] S_RCAP  = 3'd5; // PHY drives register data
    localparam logic [2:0] S_DONE  = 3'd6; // Read finished

    logic [2:0] state;
    logic [7:0] data_q;  // Link-side bus value
    logic [7:0] rdata_q; // Last byte seen with dir high
    logic       is_write;

    assign is_write = (regs.reg_op == usb_link_pkg::ULPI_OP_WRITE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_IDLE;
            data_q <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    data_q <= '0;
                    if (regs.reg_req && !ulpi_dir) begin // Only start on an idle bus
                        data_q <= {is_write ? `ULPI_CMD_REG_WRITE : `ULPI_CMD_REG_READ,
                                   regs.reg_addr};
                        state  <= S_TXCMD;
                    end
                end
                S_TXCMD: begin
                    if (ulpi_nxt) begin
                        if (is_write) begin
                            data_q <= regs.reg_wdata;
                            state  <= S_WDATA;
                        end else begin
                            data_q <= '0;
                            state  <= S_TURN;
                        end
                    end
                end
                S_WDATA: begin
                    if (ulpi_nxt) begin // PHY took the data byte
                        data_q <= '0;
                        state  <= S_STOP;
                    end
                end
                S_STOP:  state <= S_IDLE;
                S_TURN:  state <= S_RCAP; // One cycle for the PHY to take the bus
                S_RCAP:  if (!ulpi_dir) state <= S_DONE;
                S_DONE:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_RCAP && ulpi_dir) rdata_q <= ulpi_data_in;
    end

    assign ulpi_data_out  = ulpi_dir ? 8'h00 : data_q; // Release the bus to the PHY
    assign ulpi_stp       = (state == S_STOP);
    assign regs.reg_done  = (state == S_STOP) || (state == S_DONE);
    assign regs.reg_rdata = rdata_q;

    // STP only while the link owns the bus
    a_stp_dir: assert property (@(posedge clk) disable iff (rst)
        !(ulpi_stp && ulpi_dir));

endmodule

/* design/usb_link_top.sv */
// Top level of the analyzer host link; SPI from the computer in, ULPI register access out
`timescale 1ns/1ps

module usb_link_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       sclk,
    input  logic       ss,
    input  logic       mosi,
    output logic       miso,
    input  logic       sta,
    output logic [7:0] data_out,
    output logic       data_out_valid,
    output logic       err,
    input  logic [7:0] ulpi_data_in,
    output logic [7:0] ulpi_data_out,
    input  logic       ulpi_dir,
    input  logic       ulpi_nxt,
    output logic       ulpi_stp
);

    logic       busy;
    logic [7:0] reply_byte;

    cmd_stream_if link_if ();

    spi_slave_port i_spi_slave_port (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .ss         (ss),
        .mosi       (mosi),
        .sta        (sta),
        .busy       (busy),
        .reply_byte (reply_byte),
        .miso       (miso),
        .err        (err),
        .frames     (link_if)
    );

    cmd_decoder i_cmd_decoder (
        .clk            (clk),
        .rst            (rst),
        .frames         (link_if),
        .regs           (link_if),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .busy           (busy),
        .reply_byte     (reply_byte)
    );

    ulpi_reg_access i_ulpi_reg_access (
        .clk           (clk),
        .rst           (rst),
        .ulpi_data_in  (ulpi_data_in),
        .ulpi_dir      (ulpi_dir),
        .ulpi_nxt      (ulpi_nxt),
        .ulpi_data_out (ulpi_data_out),
        .ulpi_stp      (ulpi_stp),
        .regs          (link_if)
    );

endmodule

/* dv/ulpi_phy_model.sv */
// Behavioral ULPI PHY for the host link testbench; answers register TXCMDs and can stall NXT
`timescale 1ns/1ps
`include "usb_link_params.svh"

module ulpi_phy_model (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] link_data,    // Bus value driven by the link
    input  logic       stp,
    input  int         stall_cycles, // NXT delay, latched when a TXCMD shows up
    output logic [7:0] phy_data,
    output logic       dir,
    output logic       nxt
);

    localparam logic [2:0] P_IDLE  = 3'd0;
    localparam logic [2:0] P_STALL = 3'd1; // TXCMD seen, NXT held back
    localparam logic [2:0] P_ACK   = 3'd2; // NXT high for the TXCMD
    localparam logic [2:0] P_WDATA = 3'd3; // NXT high for the write data
    localparam logic [2:0] P_RTURN = 3'd4; // PHY owns the bus, turnaround
    localparam logic [2:0] P_RDATA = 3'd5; // Register value on the bus

    logic [7:0] regs [64];
    logic [7:0] last_txcmd, last_wdata; // Looked at by the testbench
    int         txcmd_cnt, stp_cnt, wait_cnt;
    logic [2:0] state;
    logic [5:0] addr;
    logic       is_wr;
    logic [7:0] data_q = 8'h00; // Known bus levels before the first reset edge
    logic       dir_q  = 1'b0;
    logic       nxt_q  = 1'b0;

    assign phy_data = data_q;
    assign dir      = dir_q;
    assign nxt      = nxt_q;

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                regs[i] <= 8'(i) ^ 8'h5a; // Pattern covers every address bit
            end
            state     <= P_IDLE;
            data_q    <= 8'h00;
            dir_q     <= 1'b0;
            nxt_q     <= 1'b0;
            txcmd_cnt <= 0;
            stp_cnt   <= 0;
            wait_cnt  <= 0;
        end else begin
            if (stp) stp_cnt <= stp_cnt + 1;
            case (state)
                P_IDLE: begin
                    if (link_data[7:6] == `ULPI_CMD_REG_WRITE ||
                        link_data[7:6] == `ULPI_CMD_REG_READ) begin
                        last_txcmd <= link_data;
                        txcmd_cnt  <= txcmd_cnt + 1;
                        addr       <= link_data[5:0];
                        is_wr      <= (link_data[7:6] == `ULPI_CMD_REG_WRITE);
                        wait_cnt   <= stall_cycles;
                        state      <= P_STALL;
                    end
                end
                P_STALL: begin
                    if (wait_cnt == 0) begin
                        nxt_q <= 1'b1;
                        state <= P_ACK;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                P_ACK: begin
                    if (is_wr) begin
                        state <= P_WDATA; // NXT stays high to take the data
                    end else begin
                        nxt_q <= 1'b0;
                        dir_q <= 1'b1;
                        state <= P_RTURN;
                    end
                end
                P_WDATA: begin
                    nxt_q      <= 1'b0;
                    regs[addr] <= link_data;
                    last_wdata <= link_data;
                    state      <= P_IDLE;
                end
                P_RTURN: begin
                    data_q <= regs[addr];
                    state  <= P_RDATA;
                end
                default: begin
                    dir_q  <= 1'b0; // Hand the bus back
                    data_q <= 8'h00;
                    state  <= P_IDLE;
                end
            endcase
        end
    end

endmodule

/* dv/usb_link_tb.sv */
// Testbench for the analyzer host link; sends SPI frames, models the PHY, checks by assertion
`timescale 1ns/1ps
`include "usb_link_params.svh"

module usb_link_tb;

    localparam int FRAME_CYC = 320;  // Worst case per frame, settle time included
    localparam int N_FRAMES  = 16;   // Frames sent over all tests
    localparam int STALL     = 2000; // NXT stall in the back-pressure test
    localparam int LIMIT     = 2 * (N_FRAMES * FRAME_CYC + STALL);

    logic       clk, rst, sclk, ss, mosi, sta, miso, err;
    logic [7:0] data_out;
    logic       data_out_valid;
    logic [7:0] ulpi_data_in, ulpi_data_out;
    logic       ulpi_dir, ulpi_nxt, ulpi_stp;
    int         stall_cycles;
    logic [7:0] shadow [64]; // Expected PHY register contents
    logic [7:0] exp_data;
    logic       dov_allowed, ulpi_quiet;
    int         err_cnt, pass_cnt, fail_cnt, mark;
    int         dov_cnt = 0;
    int         cycles  = 0;

    usb_link_top i_usb_link_top (.*);

    ulpi_phy_model i_phy (
        .clk          (clk),
        .rst          (rst),
        .link_data    (ulpi_data_out),
        .stp          (ulpi_stp),
        .stall_cycles (stall_cycles),
        .phy_data     (ulpi_data_in),
        .dir          (ulpi_dir),
        .nxt          (ulpi_nxt)
    );

    always #50 clk = ~clk;

    always @(posedge clk) if (data_out_valid) dov_cnt <= dov_cnt + 1;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic flag(input string what);
        $display("** Error at %0t ns: %s", $time, what);
        err_cnt++;
    endtask

    task automatic expect_true(input bit ok, input string what);
        assert (ok) else flag(what);
    endtask

    a_stp_pulse: assert property (@(posedge clk) disable iff (rst) ulpi_stp |=> !ulpi_stp)
        else flag("ulpi_stp high for more than one cycle");
    a_dov_value: assert property (@(posedge clk) disable iff (rst)
        data_out_valid |-> dov_allowed && data_out == exp_data)
        else flag("unexpected data_out_valid or wrong data_out");
    a_ulpi_quiet: assert property (@(posedge clk) disable iff (rst)
        ulpi_quiet |-> ulpi_data_out == 8'h00 && !ulpi_stp)
        else flag("ULPI activity where none was expected");
    a_miso_idle: assert property (@(posedge clk) disable iff (rst)
        ss && $past(ss) && $past(ss, 2) |-> !miso)
        else flag("miso high while deselected");

    // Mode 0, MSB first, 8 clk cycles per SCLK half period
    task automatic spi_frame(input logic [7:0] b0, input logic [7:0] b1, input bit st,
                             input int nbits, output logic [7:0] s0, output logic [7:0] s1);
        logic [15:0] tx;
        logic [15:0] rx;
        tx = {b0, b1};
        rx = '0;
        @(posedge clk);
        sta <= st;
        @(posedge clk);
        ss <= 1'b0;
        for (int i = 0; i < nbits; i++) begin
            sclk <= 1'b0;
            mosi <= tx[15 - i];
            repeat (8) @(posedge clk);
            rx[15 - i] = miso; // Sampled on the rising SCLK edge
            sclk <= 1'b1;
            repeat (8) @(posedge clk);
        end
        sclk <= 1'b0;
        repeat (8) @(posedge clk);
        ss   <= 1'b1;
        mosi <= 1'b0;
        repeat (16) @(posedge clk); // Frame clears the synchronizers
        s0 = rx[15:8];
        s1 = rx[7:0];
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (i_usb_link_top.busy) @(posedge clk);
    endtask

    // Full frame with random sta, then err must be clear
    task automatic clean_frame(input logic [7:0] b0, input logic [7:0] b1,
                               output logic [7:0] s0, output logic [7:0] s1);
        logic st;
        st = 1'($urandom);
        spi_frame(b0, b1, st, 16, s0, s1);
        wait_idle();
        expect_true(s0[7] == st, "status bit 7 differs from sta at SS fall");
        expect_true(!err, "err still set after a clean frame");
    endtask

    task automatic end_test(input string name);
        if (err_cnt == mark) begin
            pass_cnt++;
            $display("Test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("Test %s: failed", name);
        end
        mark = err_cnt;
    endtask

    initial begin
        logic [7:0] s0, s1, d, d2, d3;
        logic [5:0] a, a2;
        int         n_stp, n_tx, n_dov;
        void'($urandom(32'hd2bf_368e));
        clk = 1'b0;
        rst = 1'b1;
        {sclk, mosi, sta} = 3'b000;
        ss = 1'b1;
        stall_cycles = 0;
        exp_data = 8'h00;
        {dov_allowed, ulpi_quiet} = 2'b00;
        {err_cnt, pass_cnt, fail_cnt, mark} = {4{32'd0}};
        for (int i = 0; i < 64; i++) shadow[i] = 8'(i) ^ 8'h5a;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        expect_true(!err && !miso && !data_out_valid, "link outputs not idle after reset");
        expect_true(!ulpi_stp && ulpi_data_out == 8'h00, "ULPI outputs not idle after reset");
        ulpi_quiet = 1'b1;
        spi_frame(8'h00, 8'h00, 1'b1, 16, s0, s1);
        expect_true(s0[7:5] == 3'b100, "status byte wrong with sta high");
        spi_frame(8'h00, 8'h00, 1'b0, 16, s0, s1);
        expect_true(s0[7:5] == 3'b000 && !err, "status byte wrong with sta low");
        ulpi_quiet = 1'b0;
        end_test("reset and status");

        a = 6'($urandom);
        d = 8'($urandom);
        n_stp = i_phy.stp_cnt;
        clean_frame({2'b11, a}, d, s0, s1);
        expect_true(i_phy.last_txcmd == {`ULPI_CMD_REG_WRITE, a}, "write TXCMD byte wrong");
        expect_true(i_phy.last_wdata == d, "write data at the PHY wrong");
        expect_true(i_phy.stp_cnt == n_stp + 1, "write did not end with one STP pulse");
        expect_true(i_phy.regs[a] == d, "PHY register not written");
        shadow[a] = d;
        end_test("long write");

        a2 = 6'($urandom);
        clean_frame({2'b10, a2}, 8'h00, s0, s1);
        expect_true(i_phy.last_txcmd == {`ULPI_CMD_REG_READ, a2}, "read TXCMD byte wrong");
        clean_frame(8'h00, 8'h00, s0, s1);
        expect_true(s1 == shadow[a2], "read reply differs from the register");
        a2 = 6'($urandom);
        d2 = 8'($urandom);
        clean_frame({2'b11, a2}, d2, s0, s1);
        shadow[a2] = d2;
        clean_frame({2'b10, a2}, 8'h00, s0, s1);
        clean_frame(8'h00, 8'h00, s0, s1);
        expect_true(s1 == d2, "read after write returned the wrong byte");
        end_test("long read");

        d = 8'($urandom);
        exp_data    = d;
        dov_allowed = 1'b1;
        ulpi_quiet  = 1'b1;
        n_dov = dov_cnt;
        clean_frame({1'b0, `SHORT_CODE_DATA}, d, s0, s1);
        expect_true(dov_cnt == n_dov + 1, "data frame did not give one data_out_valid");
        dov_allowed = 1'b0;
        n_tx = i_phy.txcmd_cnt;
        clean_frame({1'b0, 7'(2 + $urandom_range(125))}, d, s0, s1);
        expect_true(dov_cnt == n_dov + 1 && i_phy.txcmd_cnt == n_tx,
                    "ignored short code had an effect");
        end_test("short commands");

        n_tx = i_phy.txcmd_cnt;
        spi_frame({2'b11, a}, 8'hff, 1'b0, 5, s0, s1); // SS rises after 5 bits
        expect_true(err, "err not set by a cut frame");
        clean_frame(8'h00, 8'h00, s0, s1);
        expect_true(s0[6], "status byte does not show the cut frame");
        expect_true(i_phy.txcmd_cnt == n_tx, "cut frame reached the PHY");
        ulpi_quiet = 1'b0;
        end_test("cut frame");

        a  = 6'($urandom);
        d  = 8'($urandom);
        d2 = 8'($urandom);
        d3 = 8'($urandom);
        stall_cycles <= STALL;
        spi_frame({2'b11, a}, d, 1'b0, 16, s0, s1);
        spi_frame({2'b11, a + 6'd1}, d2, 1'b0, 16, s0, s1);
        stall_cycles <= 0; // Only the first TXCMD stalls
        spi_frame({2'b11, a + 6'd2}, d3, 1'b0, 16, s0, s1);
        expect_true(s0[5] && err, "third frame not dropped while the PHY stalls");
        wait_idle();
        expect_true(i_phy.regs[a] == d && i_phy.regs[a + 6'd1] == d2,
                    "stalled writes did not complete");
        expect_true(i_phy.regs[a + 6'd2] == shadow[a + 6'd2], "dropped write changed the PHY");
        shadow[a] = d;
        shadow[a + 6'd1] = d2;
        clean_frame(8'h00, 8'h00, s0, s1);
        expect_true(s0[6], "status byte does not show the dropped frame");
        end_test("back-pressure");

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+design
design/usb_link_pkg.sv
design/cmd_stream_if.sv
design/spi_slave_port.sv
design/cmd_decoder.sv
design/ulpi_reg_access.sv
design/usb_link_top.sv
dv/ulpi_phy_model.sv
dv/usb_link_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       := usb_link_tb
RTL_TOP   := usb_link_top
FILELIST  := all.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
